// ==== source/rv32_settings.svh ====
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// Register file size, x0 included.
`define RV32_REG_COUNT 32

// First PC handed out after reset.
`define RV32_RESET_PC 32'h0000_0000

// ##############################
// Opcodes of the supported ALU subset.
// ##############################

`define RV32_OPCODE_LUI    7'b0110111
`define RV32_OPCODE_AUIPC  7'b0010111
`define RV32_OPCODE_OP_IMM 7'b0010011
`define RV32_OPCODE_OP     7'b0110011

`endif

// ==== source/rv32_pkg.sv ====
package rv32_pkg;

    // ALU operation, encoded as funct3.
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    typedef enum logic {
        IMM_I = 1'b0,
        IMM_U = 1'b1
    } imm_fmt_t;

    // First ALU operand.
    typedef enum logic [1:0] {
        SRC1_REG  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_t;

    // ##############################
    // Stage payloads.
    // ##############################

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        logic     alu_sub_sra;
        src1_t    alu_src1;
        logic     alu_src2_imm;
        imm_fmt_t imm_fmt;
        logic [4:0] rd;
        logic     rd_write;
    } decode_ctrl_t;

    typedef struct packed {
        decode_ctrl_t ctrl;
        logic [31:0]  pc;
        logic [31:0]  rs1_value;
        logic [31:0]  rs2_value;
        logic [31:0]  imm_value;
    } decode_t;

    typedef struct packed {
        logic        write;
        logic [4:0]  rd;
        logic [31:0] value;
    } writeback_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
    } retire_t;

endpackage

// ==== source/rv32_fetch.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module rv32_fetch (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    output rv32_pkg::fetch_t fetch
);
    logic [31:0] pc;

    // Every accepted word takes a PC, even one that is flushed or invalid.
    always_ff @(posedge clk) begin
        if (!stall && instr_valid) begin
            pc <= pc + 32'd4;
        end

        if (reset) begin
            pc <= `RV32_RESET_PC;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fetch.valid <= instr_valid && !flush;
            fetch.pc <= pc;
            fetch.instr <= instr;
        end

        if (reset) begin
            fetch.valid <= 1'b0;
        end
    end

endmodule

// ==== source/rv32_control_unit.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module rv32_control_unit (
    input  logic [31:0]            instr,
    output rv32_pkg::decode_ctrl_t ctrl,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2
);
    import rv32_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rd;
    logic       shift_op;
    logic       sra_op;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign shift_op = funct3 == 3'b001 || funct3 == 3'b101;
    assign sra_op   = funct7 == 7'b0100000;

    always_comb begin
        ctrl = '0;
        ctrl.rd = rd;
        ctrl.alu_op = alu_op_t'(funct3);
        ctrl.alu_src1 = SRC1_REG;
        ctrl.imm_fmt = IMM_I;

        case (opcode)
            `RV32_OPCODE_LUI: begin
                ctrl.valid = 1'b1;
                ctrl.alu_op = ALU_ADD;
                ctrl.alu_src1 = SRC1_ZERO;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.imm_fmt = IMM_U;
            end
            `RV32_OPCODE_AUIPC: begin
                ctrl.valid = 1'b1;
                ctrl.alu_op = ALU_ADD;
                ctrl.alu_src1 = SRC1_PC;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.imm_fmt = IMM_U;
            end
            `RV32_OPCODE_OP_IMM: begin
                ctrl.alu_src2_imm = 1'b1;
                // Shift immediates reuse funct7 and only SRAI may set bit 30.
                if (!shift_op || funct7 == 7'b0000000) begin
                    ctrl.valid = 1'b1;
                end else if (sra_op && funct3 == 3'b101) begin
                    ctrl.valid = 1'b1;
                    ctrl.alu_sub_sra = 1'b1;
                end
            end
            `RV32_OPCODE_OP: begin
                if (funct7 == 7'b0000000) begin
                    ctrl.valid = 1'b1;
                end else if (sra_op && (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    ctrl.valid = 1'b1;
                    ctrl.alu_sub_sra = 1'b1;
                end
            end
            default: begin
                ctrl.valid = 1'b0;
            end
        endcase

        // Writes to x0 are dropped here.
        ctrl.rd_write = ctrl.valid && rd != 5'd0;
    end

endmodule

// ==== source/rv32_imm_mux.sv ====
`timescale 1ns/1ns

module rv32_imm_mux (
    input  rv32_pkg::imm_fmt_t imm_fmt,
    input  logic [31:0]        instr,
    output logic [31:0]        imm_value
);
    import rv32_pkg::*;

    // Shift amount sits in instr[24:20], the low bits of the I immediate.
    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm_value = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_U: begin
                imm_value = {instr[31:12], 12'b0};
            end
            default: begin
                imm_value = 32'b0;
            end
        endcase
    end

endmodule

// ==== source/rv32_regs.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module rv32_regs (
    input  logic                 clk,
    input  logic                 stall,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    input  rv32_pkg::writeback_t writeback,
    output logic [31:0]          rs1_value,
    output logic [31:0]          rs2_value
);
    logic [31:0] regs [`RV32_REG_COUNT];

    // Read with write-through from the instruction in execute.
    function automatic logic [31:0] read_reg(input logic [4:0] index);
        logic [31:0] value;
        if (index == 5'd0) begin
            value = 32'b0;
        end else if (writeback.write && writeback.rd == index) begin
            value = writeback.value;
        end else begin
            value = regs[index];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (!stall && writeback.write && writeback.rd != 5'd0) begin
            regs[writeback.rd] <= writeback.value;
        end
    end

    assign rs1_value = read_reg(rs1);
    assign rs2_value = read_reg(rs2);

endmodule

// ==== source/rv32_decode.sv ====
`timescale 1ns/1ns

module rv32_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  rv32_pkg::fetch_t     fetch,
    input  rv32_pkg::writeback_t writeback,
    output rv32_pkg::decode_t    decoded
);
    import rv32_pkg::*;

    logic [4:0]   rs1;
    logic [4:0]   rs2;
    decode_ctrl_t ctrl;
    logic [31:0]  rs1_value;
    logic [31:0]  rs2_value;
    logic [31:0]  imm_value;
    logic         issue;

    rv32_control_unit control_unit (
        .instr(fetch.instr),
        .ctrl(ctrl),
        .rs1(rs1),
        .rs2(rs2)
    );

    rv32_regs regs (
        .clk(clk),
        .stall(stall),
        .rs1(rs1),
        .rs2(rs2),
        .writeback(writeback),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value)
    );

    rv32_imm_mux imm_mux (
        .imm_fmt(ctrl.imm_fmt),
        .instr(fetch.instr),
        .imm_value(imm_value)
    );

    assign issue = fetch.valid && ctrl.valid && !flush;

    // ##############################
    // Pipeline register.
    // ##############################

    always_ff @(posedge clk) begin
        if (!stall) begin
            decoded.ctrl <= ctrl;
            decoded.ctrl.valid <= issue;
            decoded.ctrl.rd_write <= issue && ctrl.rd_write;
            decoded.pc <= fetch.pc;
            decoded.rs1_value <= rs1_value;
            decoded.rs2_value <= rs2_value;
            decoded.imm_value <= imm_value;
        end

        if (reset) begin
            decoded.ctrl.valid <= 1'b0;
            decoded.ctrl.rd_write <= 1'b0;
        end
    end

endmodule

// ==== source/rv32_execute.sv ====
`timescale 1ns/1ns

module rv32_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  rv32_pkg::decode_t    decoded,
    output rv32_pkg::writeback_t writeback,
    output rv32_pkg::retire_t    retire
);
    import rv32_pkg::*;

    logic [31:0] src1;
    logic [31:0] src2;
    logic [4:0]  shamt;
    logic [31:0] sra_value;
    logic [31:0] result;

    // ##############################
    // Operands.
    // ##############################

    always_comb begin
        case (decoded.ctrl.alu_src1)
            SRC1_REG: src1 = decoded.rs1_value;
            SRC1_PC:  src1 = decoded.pc;
            default:  src1 = 32'b0;
        endcase
    end

    assign src2  = decoded.ctrl.alu_src2_imm ? decoded.imm_value : decoded.rs2_value;
    assign shamt = src2[4:0];

    // Arithmetic right shift of the first operand.
    assign sra_value = $signed(src1) >>> shamt;

    always_comb begin
        case (decoded.ctrl.alu_op)
            ALU_ADD:  result = decoded.ctrl.alu_sub_sra ? src1 - src2 : src1 + src2;
            ALU_SLL:  result = src1 << shamt;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_XOR:  result = src1 ^ src2;
            ALU_SRL:  result = decoded.ctrl.alu_sub_sra ? sra_value : src1 >> shamt;
            ALU_OR:   result = src1 | src2;
            ALU_AND:  result = src1 & src2;
            default:  result = 32'b0;
        endcase
    end

    assign writeback.write = decoded.ctrl.valid && decoded.ctrl.rd_write;
    assign writeback.rd    = decoded.ctrl.rd;
    assign writeback.value = result;

    // The retire report shows zero for x0 targets.
    always_ff @(posedge clk) begin
        if (!stall) begin
            retire.valid <= decoded.ctrl.valid;
            retire.pc <= decoded.pc;
            retire.rd <= decoded.ctrl.rd;
            retire.value <= decoded.ctrl.rd_write ? result : 32'b0;
        end

        if (reset) begin
            retire.valid <= 1'b0;
        end
    end

endmodule

// ==== source/rv32_core.sv ====
`timescale 1ns/1ns

module rv32_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  logic              stall,
    input  logic              flush,
    output rv32_pkg::retire_t retire
);
    import rv32_pkg::*;

    fetch_t     fetch;
    decode_t    decoded;
    writeback_t writeback;

    rv32_fetch fetch_stage (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .instr_valid(instr_valid),
        .instr(instr),
        .fetch(fetch)
    );

    rv32_decode decode_stage (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .fetch(fetch),
        .writeback(writeback),
        .decoded(decoded)
    );

    // Writeback loops back to the register file in decode.
    rv32_execute execute_stage (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .decoded(decoded),
        .writeback(writeback),
        .retire(retire)
    );

endmodule

// ==== testbench/rv32_decode_assertions.sv ====
`timescale 1ns/1ns

module rv32_decode_assertions (
    input logic              clk,
    input logic              reset,
    input logic              stall,
    input logic              flush,
    input rv32_pkg::decode_t decoded
);
    int failures = 0;

    reset_clears_valid: assert property (@(posedge clk)
        reset |=> !decoded.ctrl.valid && !decoded.ctrl.rd_write)
        else begin
            $error("decode output still valid after a reset edge");
            failures++;
        end

    // Flush only acts on an edge that is not stalled.
    flush_clears_valid: assert property (@(posedge clk) disable iff (reset)
        flush && !stall |=> !decoded.ctrl.valid)
        else begin
            $error("decode output valid after a flush edge");
            failures++;
        end

    stall_holds_output: assert property (@(posedge clk) disable iff (reset)
        stall |=> decoded === $past(decoded))
        else begin
            $error("decode output changed across a stalled edge");
            failures++;
        end

endmodule

bind rv32_decode rv32_decode_assertions decode_checks (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .flush(flush),
    .decoded(decoded)
);

// ==== testbench/rv32_core_tb.sv ====
`timescale 1ns/1ns
`include "rv32_settings.svh"

module rv32_core_tb;
    import rv32_pkg::*;

    typedef struct packed {
        logic        killed;
        logic [31:0] accept_edge;
        logic [31:0] pc;
        logic [31:0] instr;
    } accepted_t;

    typedef struct packed {
        logic [31:0] retire_edge;
        retire_t     report;
    } expected_t;

    localparam int RESET_CYCLES = 10;
    localparam int N_INIT = 5 + 2 * 31;
    localparam int N_OP = 200;
    localparam int N_IMM = 150;
    localparam int N_STALL = 240;
    localparam int N_FLUSH = 200;
    localparam int N_MISC = 80;
    localparam int CYCLE_LIMIT = RESET_CYCLES + N_INIT + N_OP + N_IMM + N_STALL + N_FLUSH
                                 + N_MISC + 6 * 10 + 50;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        stall;
    logic        flush;
    retire_t     retire;
    retire_t     last_retire;
    logic [31:0] shadow [`RV32_REG_COUNT];
    logic [31:0] model_pc;
    logic [31:0] edge_count;
    logic        live_edge;
    logic        stalled_edge;
    logic [4:0]  last_rd;
    accepted_t   pending [$];
    expected_t   expected [$];
    int          errors;
    int          checks;
    int          test_errors;
    int          cycles;
    event        checked;

    rv32_core uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ##############################
    // Reference model.
    // ##############################

    function automatic retire_t predict_retire(input logic [31:0] pc, input logic [31:0] word);
        retire_t     r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        logic [4:0]  sh;
        logic        alt;
        logic        shift;
        a = shadow[word[19:15]];
        b = word[6:0] == `RV32_OPCODE_OP ? shadow[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sh = b[4:0];
        alt = word[31:25] == 7'b0100000;
        shift = word[13:12] == 2'b01;
        case (word[14:12])
            3'b000: value = (alt && word[6:0] == `RV32_OPCODE_OP) ? a - b : a + b;
            3'b001: value = a << sh;
            3'b010: value = {31'b0, (a[31] != b[31]) ? a[31] : a < b};
            3'b011: value = {31'b0, a < b};
            3'b100: value = a ^ b;
            3'b101: value = alt ? (a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}}) : a >> sh;
            3'b110: value = a | b;
            default: value = a & b;
        endcase
        r = '0;
        case (word[6:0])
            `RV32_OPCODE_LUI: r.valid = 1'b1;
            `RV32_OPCODE_AUIPC: r.valid = 1'b1;
            `RV32_OPCODE_OP_IMM: r.valid = !shift || word[31:25] == 7'b0 || (alt && word[14]);
            `RV32_OPCODE_OP: r.valid = word[31:25] == 7'b0
                                       || (alt && (word[14:12] == 3'b000
                                                   || word[14:12] == 3'b101));
            default: r.valid = 1'b0;
        endcase
        if (word[6:0] == `RV32_OPCODE_LUI) begin
            value = {word[31:12], 12'b0};
        end else if (word[6:0] == `RV32_OPCODE_AUIPC) begin
            value = pc + {word[31:12], 12'b0};
        end
        r.pc = pc;
        r.rd = word[11:7];
        r.value = word[11:7] == 5'd0 ? 32'b0 : value;
        return r;
    endfunction

    // Kind 0 OP, 1 OP-IMM, 2 LUI, 3 AUIPC, 4 load, 5 OP with a bad funct7.
    function automatic logic [31:0] random_word(input int kind, input logic [4:0] rd,
                                                input logic [4:0] rs1);
        logic [31:0] word;
        logic [2:0]  f3;
        logic [6:0]  f7;
        f3 = 3'($urandom);
        f7 = ($urandom_range(0, 1) && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
        word = $urandom;
        case (kind)
            0: word = {f7, word[24:20], rs1, f3, rd, `RV32_OPCODE_OP};
            1: word[19:0] = {rs1, f3, rd, `RV32_OPCODE_OP_IMM};
            2: word[11:0] = {rd, `RV32_OPCODE_LUI};
            3: word[11:0] = {rd, `RV32_OPCODE_AUIPC};
            4: word[19:0] = {rs1, f3, rd, 7'b0000011};
            default: word = {7'b0000001, word[24:20], rs1, f3, rd, `RV32_OPCODE_OP};
        endcase
        if (kind == 1 && f3[1:0] == 2'b01) begin
            word[31:25] = f7;
        end
        return word;
    endfunction

    // Tracks what the DUT samples; an entry settles once its flush window has passed.
    always @(posedge clk) begin : monitor
        accepted_t entry;
        retire_t   report;
        live_edge = !reset;
        stalled_edge = stall;
        if (reset) begin
            model_pc = `RV32_RESET_PC;
            edge_count = 32'd0;
            for (int i = 0; i < `RV32_REG_COUNT; i++) begin
                shadow[i] = 32'b0;
            end
        end else if (!stall) begin
            edge_count = edge_count + 32'd1;
            foreach (pending[i]) begin
                if (flush && pending[i].accept_edge + 32'd1 >= edge_count) begin
                    pending[i].killed = 1'b1;
                end
            end
            if (instr_valid) begin
                pending.push_back(accepted_t'{flush, edge_count, model_pc, instr});
                model_pc = model_pc + 32'd4;
            end
            while (pending.size() != 0 && pending[0].accept_edge < edge_count) begin
                entry = pending.pop_front();
                report = predict_retire(entry.pc, entry.instr);
                if (!entry.killed && report.valid) begin
                    expected.push_back(expected_t'{entry.accept_edge + 32'd2, report});
                    if (report.rd != 5'd0) begin
                        shadow[report.rd] = report.value;
                    end
                end
            end
        end
    end

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    always @(negedge clk) begin : check_retire
        expected_t want;
        if (live_edge && stalled_edge) begin
            assert (retire === last_retire) else begin
                $display("retire report changed across a stalled edge at cycle %0d", cycles);
                errors++;
            end
        end else if (live_edge && retire.valid !== 1'b0) begin
            assert (expected.size() != 0) else begin
                $display("unexpected retire at pc %h", retire.pc);
                errors++;
            end
            if (expected.size() != 0) begin
                want = expected.pop_front();
                check_field("retire.pc", retire.pc, want.report.pc);
                check_field("retire.rd", 32'(retire.rd), 32'(want.report.rd));
                check_field("retire.value", retire.value, want.report.value);
                assert (edge_count == want.retire_edge) else begin
                    $display("pc %h retired on edge %0d instead of edge %0d",
                             retire.pc, edge_count, want.retire_edge);
                    errors++;
                end
            end
        end
        last_retire = retire;
        -> checked;
    end

    // ##############################
    // Stimulus.
    // ##############################

    task automatic drive(input logic valid, input logic [31:0] word, input logic st,
                         input logic fl);
        @(posedge clk);
        instr_valid <= valid;
        instr <= word;
        stall <= st;
        flush <= fl;
    endtask

    task automatic drain_and_report(input string name);
        do begin
            drive(1'b0, 32'b0, 1'b0, 1'b0);
            @(checked);
        end while (pending.size() != 0 || expected.size() != 0);
        $display("%s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // Stall and flush chances are out of 16; half the words read the previous rd.
    task automatic run_stream(input int count, input int min_kind, input int max_kind,
                              input int stall_chance, input int flush_chance,
                              input logic to_x0);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic       st;
        for (int i = 0; i < count; i++) begin
            rd = (to_x0 && $urandom_range(0, 2) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
            rs1 = $urandom_range(0, 1) ? last_rd : 5'($urandom);
            st = $urandom_range(0, 15) < stall_chance;
            drive(1'b1, random_word($urandom_range(min_kind, max_kind), rd, rs1), st,
                  !st && $urandom_range(0, 15) < flush_chance);
            if (!st) begin
                last_rd = rd;
            end
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles with %0d retires outstanding",
                 cycles, expected.size());
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h9f01));
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = 32'b0;
        stall = 1'b0;
        flush = 1'b0;
        errors = 0;
        checks = 0;
        test_errors = 0;
        last_rd = 5'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (5) drive(1'b0, 32'b0, 1'b0, 1'b0);
        // Load every register so later reads are defined.
        for (int r = 1; r < `RV32_REG_COUNT; r++) begin
            drive(1'b1, random_word(2, 5'(r), 5'd0), 1'b0, 1'b0);
            drive(1'b1, {12'($urandom), 5'(r), 3'b000, 5'(r), `RV32_OPCODE_OP_IMM}, 1'b0, 1'b0);
        end
        drain_and_report("reset latency and register init");
        run_stream(N_OP, 0, 0, 0, 0, 1'b0);
        drain_and_report("op chains");
        run_stream(N_IMM, 1, 3, 0, 0, 1'b0);
        drain_and_report("op-imm, lui, auipc");
        run_stream(N_STALL, 0, 3, 6, 0, 1'b0);
        drain_and_report("random stall");
        run_stream(N_FLUSH, 0, 3, 2, 3, 1'b0);
        drain_and_report("flush pulses");
        run_stream(N_MISC, 0, 5, 0, 0, 1'b1);
        drain_and_report("unsupported and x0");
        assert (uut.decode_stage.decode_checks.failures == 0) else begin
            $display("decode stage assertions failed %0d times",
                     uut.decode_stage.decode_checks.failures);
            errors++;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+source
source/rv32_pkg.sv
source/rv32_fetch.sv
source/rv32_control_unit.sv
source/rv32_imm_mux.sv
source/rv32_regs.sv
source/rv32_decode.sv
source/rv32_execute.sv
source/rv32_core.sv
testbench/rv32_decode_assertions.sv
testbench/rv32_core_tb.sv
